//--- source/racer_cfg.svh
`ifndef RACER_CFG_SVH
`define RACER_CFG_SVH

// fixed-point formats
`define RACER_ANG_W            9
`define RACER_VFRAC            8   // velocity and position fraction bits
`define RACER_VINT             8   // includes sign
`define RACER_AFRAC            4   // throttle fraction bits
`define RACER_FRICTION_SHIFT   4
`define RACER_VMAX             12

// arena limits in whole units
`define RACER_XMIN             (-800)
`define RACER_XMAX             800
`define RACER_YMIN             (-400)
`define RACER_YMAX             400

`define RACER_CAR1_X0          350
`define RACER_CAR1_Y0          32
`define RACER_CAR2_X0          300
`define RACER_CAR2_Y0          0
`define RACER_INIT_ANGLE       90

`define RACER_CORDIC_ITER      12
`define RACER_CORDIC_AFRAC     8
// atan(2^-i) in degrees times 256
`define RACER_CORDIC_ATAN_0    11520
`define RACER_CORDIC_ATAN_1    6801
`define RACER_CORDIC_ATAN_2    3593
`define RACER_CORDIC_ATAN_3    1824
`define RACER_CORDIC_ATAN_4    916
`define RACER_CORDIC_ATAN_5    458
`define RACER_CORDIC_ATAN_6    229
`define RACER_CORDIC_ATAN_7    115
`define RACER_CORDIC_ATAN_8    57
`define RACER_CORDIC_ATAN_9    29
`define RACER_CORDIC_ATAN_10   14
`define RACER_CORDIC_ATAN_11   7
`define RACER_CORDIC_GAIN      39797 // 0.60725 * 2^16

`endif

//--- source/racer_pkg.sv
`default_nettype none
`include "racer_cfg.svh"

package racer_pkg;

    typedef logic signed [`RACER_VINT+`RACER_VFRAC-1:0] speed_t; // 8.8
    typedef logic signed [`RACER_VFRAC+11:0]            pos_t;   // 12.8
    typedef logic        [`RACER_ANG_W-1:0]             angle_t; // 0 to 359
    typedef logic signed [11:0]                         coord_t; // whole units

    typedef struct packed {
        logic [2:0] acc;   // 0 to 7
        logic [1:0] omega; // bit0 hold, else bit1 picks +1 or -1
    } car_cmd_t;

    typedef struct packed {
        speed_t vx;
        speed_t vy;
    } vel_vec_t;

    typedef struct packed {
        pos_t x;
        pos_t y;
    } car_pos_t;

    typedef struct packed {
        angle_t heading;
        coord_t x;
        coord_t y;
        speed_t speed;
    } car_out_t;

endpackage

`default_nettype wire

//--- source/steer_angle.sv
`timescale 1ns/1ns
`default_nettype none
`include "racer_cfg.svh"

module steer_angle (
    input  wire                     car1_v_decomposition_done,
    input  wire                     i_rst_n,
    input  wire                     i_en,
    input  wire  [1:0]              i_omega,
    output racer_pkg::angle_t       o_angle
);

    localparam racer_pkg::angle_t LAST_DEG = racer_pkg::angle_t'(359);

    racer_pkg::angle_t angle_r;
    racer_pkg::angle_t angle_nx;

    always_comb begin
        angle_nx = angle_r;
        if (!i_omega[0]) begin
            if (i_omega[1]) begin
                // turn left, 359 rolls over to 0
                angle_nx = (angle_r == LAST_DEG) ? '0 : angle_r + 1'b1;
            end else begin
                angle_nx = (angle_r == '0) ? LAST_DEG : angle_r - 1'b1;
            end
        end
    end

    always_ff @(posedge car1_v_decomposition_done or negedge i_rst_n) begin
        if (!i_rst_n) begin
            angle_r <= racer_pkg::angle_t'(`RACER_INIT_ANGLE);
        end else if (i_en) begin
            angle_r <= angle_nx;
        end
    end

    assign o_angle = angle_r;

endmodule

`default_nettype wire

//--- source/speed_update.sv
`timescale 1ns/1ns
`default_nettype none
`include "racer_cfg.svh"

module speed_update (
    input  wire                     car1_v_decomposition_done,
    input  wire                     i_rst_n,
    input  wire                     i_en,
    input  wire  [2:0]              i_acc,
    output racer_pkg::speed_t       o_speed
);

    localparam int SW = $bits(racer_pkg::speed_t);
    localparam int EW = SW + 2; // room for the sum before clamping

    localparam logic signed [EW-1:0] VTOP = `RACER_VMAX <<< `RACER_VFRAC;

    racer_pkg::speed_t     speed_r;
    logic signed [EW-1:0]  v_ext;
    logic signed [EW-1:0]  acc_term;
    logic signed [EW-1:0]  v_sum;
    logic signed [EW-1:0]  v_clamp;

    assign v_ext    = EW'(speed_r);
    assign acc_term = EW'(i_acc) <<< (`RACER_VFRAC - `RACER_AFRAC); // align 3.4 to 8.8

    // friction takes 1/16 of the old speed
    assign v_sum = v_ext - (v_ext >>> `RACER_FRICTION_SHIFT) + acc_term;

    always_comb begin
        v_clamp = v_sum;
        if (v_sum < 0) begin
            v_clamp = '0;
        end else if (v_sum > VTOP) begin
            v_clamp = VTOP;
        end
    end

    always_ff @(posedge car1_v_decomposition_done or negedge i_rst_n) begin
        if (!i_rst_n) begin
            speed_r <= '0;
        end else if (i_en) begin
            speed_r <= v_clamp[SW-1:0];
        end
    end

    assign o_speed = speed_r;

endmodule

`default_nettype wire

//--- source/cordic_rotate.sv
`timescale 1ns/1ns
`default_nettype none
`include "racer_cfg.svh"

module cordic_rotate (
    input  wire                            car1_v_decomposition_done,
    input  wire                            i_rst_n,
    input  wire                            i_start,
    input  wire racer_pkg::speed_t         i_mag,
    input  wire signed [`RACER_ANG_W-1:0]  i_angle, // -180 to 179
    output logic                           o_done,
    output racer_pkg::vel_vec_t            o_vec
);

    localparam int SW   = $bits(racer_pkg::speed_t);
    localparam int XW   = SW + 2;                               // gain of 1.647 needs headroom
    localparam int ZW   = `RACER_ANG_W + `RACER_CORDIC_AFRAC;
    localparam int AW   = `RACER_ANG_W;
    localparam int CW   = $clog2(`RACER_CORDIC_ITER + 2);
    localparam int ITER = `RACER_CORDIC_ITER;

    localparam logic [CW-1:0]        LAST = CW'(ITER + 1);  // scale step
    localparam logic signed [AW-1:0] A90  = 90;
    localparam logic signed [AW-1:0] A180 = 180;
    localparam logic signed [17:0]   GAIN = `RACER_CORDIC_GAIN;

    logic                 busy;
    logic [CW-1:0]        cnt;
    logic [CW-1:0]        idx;
    racer_pkg::speed_t    mag_r;
    logic signed [AW-1:0] ang_r;
    logic signed [XW-1:0] x_r, y_r;
    logic signed [ZW-1:0] z_r;
    logic signed [XW-1:0] pre_x;
    logic signed [AW-1:0] pre_ang;
    logic signed [ZW-1:0] pre_z;
    logic signed [XW-1:0] it_x, it_y;
    logic signed [ZW-1:0] it_z;
    logic signed [XW+17:0] prod_x, prod_y;

    function automatic logic signed [ZW-1:0] atan_lut(input logic [CW-1:0] i);
        case (i)
            0:       atan_lut = ZW'(`RACER_CORDIC_ATAN_0);
            1:       atan_lut = ZW'(`RACER_CORDIC_ATAN_1);
            2:       atan_lut = ZW'(`RACER_CORDIC_ATAN_2);
            3:       atan_lut = ZW'(`RACER_CORDIC_ATAN_3);
            4:       atan_lut = ZW'(`RACER_CORDIC_ATAN_4);
            5:       atan_lut = ZW'(`RACER_CORDIC_ATAN_5);
            6:       atan_lut = ZW'(`RACER_CORDIC_ATAN_6);
            7:       atan_lut = ZW'(`RACER_CORDIC_ATAN_7);
            8:       atan_lut = ZW'(`RACER_CORDIC_ATAN_8);
            9:       atan_lut = ZW'(`RACER_CORDIC_ATAN_9);
            10:      atan_lut = ZW'(`RACER_CORDIC_ATAN_10);
            11:      atan_lut = ZW'(`RACER_CORDIC_ATAN_11);
            default: atan_lut = '0;
        endcase
    endfunction

    // fold the angle into -90..90, flipping x for the far half
    always_comb begin
        pre_x   = XW'(mag_r);
        pre_ang = ang_r;
        if (ang_r > A90) begin
            pre_ang = ang_r - A180;
            pre_x   = -pre_x;
        end else if (ang_r < -A90) begin
            pre_ang = ang_r + A180;
            pre_x   = -pre_x;
        end
        pre_z = ZW'(pre_ang) <<< `RACER_CORDIC_AFRAC;
    end

    assign idx = cnt - 1'b1; // step index during iterations

    always_comb begin
        if (z_r >= 0) begin
            it_x = x_r - (y_r >>> idx);
            it_y = y_r + (x_r >>> idx);
            it_z = z_r - atan_lut(idx);
        end else begin
            it_x = x_r + (y_r >>> idx);
            it_y = y_r - (x_r >>> idx);
            it_z = z_r + atan_lut(idx);
        end
    end

    assign prod_x = x_r * GAIN;
    assign prod_y = y_r * GAIN;

    always_ff @(posedge car1_v_decomposition_done or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy   <= 1'b0;
            cnt    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (!busy) begin
                if (i_start) begin
                    busy <= 1'b1;
                    cnt  <= '0;
                end
            end else if (cnt == LAST) begin
                busy   <= 1'b0;
                o_done <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge car1_v_decomposition_done) begin
        if (!busy && i_start) begin
            mag_r <= i_mag;
            ang_r <= i_angle;
        end
        if (busy) begin
            if (cnt == '0) begin        // load and pre-rotate
                x_r <= pre_x;
                y_r <= '0;
                z_r <= pre_z;
            end else if (cnt != LAST) begin
                x_r <= it_x;
                y_r <= it_y;
                z_r <= it_z;
            end else begin              // gain correction, >>> 16
                o_vec.vx <= prod_x[16 +: SW];
                o_vec.vy <= prod_y[16 +: SW];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/position_integrate.sv
`timescale 1ns/1ns
`default_nettype none
`include "racer_cfg.svh"

module position_integrate #(
    parameter int INIT_X = 0,
    parameter int INIT_Y = 0
) (
    input  wire                       car1_v_decomposition_done,
    input  wire                       i_rst_n,
    input  wire                       i_en,
    input  wire racer_pkg::vel_vec_t  i_vel,
    output racer_pkg::coord_t         o_x,
    output racer_pkg::coord_t         o_y
);

    localparam int PW = $bits(racer_pkg::pos_t);
    localparam int CW = $bits(racer_pkg::coord_t);

    localparam racer_pkg::pos_t X0  = racer_pkg::pos_t'(INIT_X <<< `RACER_VFRAC);
    localparam racer_pkg::pos_t Y0  = racer_pkg::pos_t'(INIT_Y <<< `RACER_VFRAC);
    localparam racer_pkg::pos_t XLO = racer_pkg::pos_t'(`RACER_XMIN <<< `RACER_VFRAC);
    localparam racer_pkg::pos_t XHI = racer_pkg::pos_t'(`RACER_XMAX <<< `RACER_VFRAC);
    localparam racer_pkg::pos_t YLO = racer_pkg::pos_t'(`RACER_YMIN <<< `RACER_VFRAC);
    localparam racer_pkg::pos_t YHI = racer_pkg::pos_t'(`RACER_YMAX <<< `RACER_VFRAC);

    racer_pkg::car_pos_t pos_r;

    function automatic racer_pkg::pos_t step_axis(input racer_pkg::pos_t p,
                                                  input racer_pkg::speed_t v,
                                                  input racer_pkg::pos_t lo,
                                                  input racer_pkg::pos_t hi);
        logic signed [PW:0] sum;
        sum = (PW+1)'(p) + (PW+1)'(v);
        if (sum <= (PW+1)'(lo)) return lo;   // pinned to the wall
        if (sum >= (PW+1)'(hi)) return hi;
        return sum[PW-1:0];
    endfunction

    // round half up on the dropped fraction
    function automatic racer_pkg::coord_t round_pos(input racer_pkg::pos_t p);
        racer_pkg::coord_t whole;
        whole = racer_pkg::coord_t'(p >>> `RACER_VFRAC);
        return whole + $signed({{(CW-1){1'b0}}, p[`RACER_VFRAC-1]});
    endfunction

    always_ff @(posedge car1_v_decomposition_done or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pos_r.x <= X0;
            pos_r.y <= Y0;
        end else if (i_en) begin
            pos_r.x <= step_axis(pos_r.x, i_vel.vx, XLO, XHI);
            pos_r.y <= step_axis(pos_r.y, i_vel.vy, YLO, YHI);
        end
    end

    assign o_x = round_pos(pos_r.x);
    assign o_y = round_pos(pos_r.y);

endmodule

`default_nettype wire

//--- source/car_dynamics.sv
`timescale 1ns/1ns
`default_nettype none
`include "racer_cfg.svh"

module car_dynamics #(
    parameter int INIT_X = 0,
    parameter int INIT_Y = 0
) (
    input  wire                       car1_v_decomposition_done,
    input  wire                       i_rst_n,
    input  wire                       i_frame_go,
    input  wire racer_pkg::car_cmd_t  i_cmd,
    output logic                      o_idle,
    output racer_pkg::car_out_t       o_car
);

    racer_pkg::angle_t    heading;
    racer_pkg::speed_t    speed;
    racer_pkg::coord_t    pos_x, pos_y;
    racer_pkg::vel_vec_t  vel_r;      // vector from the last decomposition
    racer_pkg::vel_vec_t  rot_vec;
    logic                 rot_done;
    logic                 start_r;
    logic                 busy_r;
    logic signed [`RACER_ANG_W-1:0] rot_angle;

    steer_angle u_steer (
        .car1_v_decomposition_done (car1_v_decomposition_done),
        .i_rst_n                   (i_rst_n),
        .i_en                      (i_frame_go),
        .i_omega                   (i_cmd.omega),
        .o_angle                   (heading)
    );

    speed_update u_speed (
        .car1_v_decomposition_done (car1_v_decomposition_done),
        .i_rst_n                   (i_rst_n),
        .i_en                      (i_frame_go),
        .i_acc                     (i_cmd.acc),
        .o_speed                   (speed)
    );

    // moves with the vector of the previous frame
    position_integrate #(
        .INIT_X (INIT_X),
        .INIT_Y (INIT_Y)
    ) u_pos (
        .car1_v_decomposition_done (car1_v_decomposition_done),
        .i_rst_n                   (i_rst_n),
        .i_en                      (i_frame_go),
        .i_vel                     (vel_r),
        .o_x                       (pos_x),
        .o_y                       (pos_y)
    );

    // 180..359 maps onto -180..-1, 9-bit wrap does the subtraction
    assign rot_angle = (heading >= 9'd180) ? $signed(heading - 9'd360) : $signed(heading);

    cordic_rotate u_cordic (
        .car1_v_decomposition_done (car1_v_decomposition_done),
        .i_rst_n                   (i_rst_n),
        .i_start                   (start_r),
        .i_mag                     (speed),
        .i_angle                   (rot_angle),
        .o_done                    (rot_done),
        .o_vec                     (rot_vec)
    );

    always_ff @(posedge car1_v_decomposition_done or negedge i_rst_n) begin
        if (!i_rst_n) begin
            start_r <= 1'b0;
            busy_r  <= 1'b0;
            vel_r   <= '0;
        end else begin
            start_r <= i_frame_go; // new speed and heading are valid now
            if (i_frame_go) begin
                busy_r <= 1'b1;
            end else if (rot_done) begin
                busy_r <= 1'b0;
                vel_r  <= rot_vec;
            end
        end
    end

    assign o_idle = ~busy_r;
    assign o_car  = '{heading: heading, x: pos_x, y: pos_y, speed: speed};

endmodule

`default_nettype wire

//--- source/race_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "racer_cfg.svh"

module race_core (
    input  wire                       car1_v_decomposition_done,
    input  wire                       i_rst_n,
    input  wire                       i_step,
    input  wire racer_pkg::car_cmd_t  i_car1_cmd,
    input  wire racer_pkg::car_cmd_t  i_car2_cmd,
    output logic                      o_ready,
    output racer_pkg::car_out_t       o_car1,
    output racer_pkg::car_out_t       o_car2
);

    logic frame_go;
    logic car1_idle, car2_idle;

    // steps while either car is busy are dropped
    assign o_ready  = car1_idle & car2_idle;
    assign frame_go = i_step & o_ready;

    car_dynamics #(
        .INIT_X (`RACER_CAR1_X0),
        .INIT_Y (`RACER_CAR1_Y0)
    ) u_car1 (
        .car1_v_decomposition_done (car1_v_decomposition_done),
        .i_rst_n                   (i_rst_n),
        .i_frame_go                (frame_go),
        .i_cmd                     (i_car1_cmd),
        .o_idle                    (car1_idle),
        .o_car                     (o_car1)
    );

    car_dynamics #(
        .INIT_X (`RACER_CAR2_X0),
        .INIT_Y (`RACER_CAR2_Y0)
    ) u_car2 (
        .car1_v_decomposition_done (car1_v_decomposition_done),
        .i_rst_n                   (i_rst_n),
        .i_frame_go                (frame_go),
        .i_cmd                     (i_car2_cmd),
        .o_idle                    (car2_idle),
        .o_car                     (o_car2)
    );

endmodule

`default_nettype wire

//--- tb/race_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "racer_cfg.svh"

module race_checker (
    input  wire                       car1_v_decomposition_done,
    input  wire                       i_rst_n,
    input  wire                       i_step,
    input  wire racer_pkg::car_cmd_t  i_car1_cmd,
    input  wire racer_pkg::car_cmd_t  i_car2_cmd,
    input  wire                       i_ready,
    input  wire racer_pkg::car_out_t  i_car1,
    input  wire racer_pkg::car_out_t  i_car2,
    output int                        o_errors
);

    localparam int ONE  = 1 << `RACER_VFRAC;
    localparam int VTOP = `RACER_VMAX * ONE;
    localparam int XLO  = `RACER_XMIN * ONE;
    localparam int XHI  = `RACER_XMAX * ONE;
    localparam int YLO  = `RACER_YMIN * ONE;
    localparam int YHI  = `RACER_YMAX * ONE;
    localparam int READY_LAT = 16; // accepting edge to ready high

    // reference state per car in the DUT's fixed-point scaling
    int    head [2];
    int    speed [2];
    int    px [2];
    int    py [2];
    int    vx [2];
    int    vy [2];
    int    atan_tab [`RACER_CORDIC_ITER];
    string cur_test    = "none";
    int    test_checks = 0;
    int    test_errs   = 0;
    int    n_tests     = 0;
    int    n_failed    = 0;
    int    n_checks    = 0;
    int    total_errs  = 0;
    logic  pending     = 1'b0; // frame accepted, ready not yet back
    int    busy_cycles = 0;

    assign o_errors = total_errs;

    task automatic init_model();
        head[0] = `RACER_INIT_ANGLE;
        head[1] = `RACER_INIT_ANGLE;
        speed[0] = 0;
        speed[1] = 0;
        px[0] = `RACER_CAR1_X0 * ONE;
        py[0] = `RACER_CAR1_Y0 * ONE;
        px[1] = `RACER_CAR2_X0 * ONE;
        py[1] = `RACER_CAR2_Y0 * ONE;
        vx[0] = 0;
        vy[0] = 0;
        vx[1] = 0;
        vy[1] = 0;
    endtask

    initial begin
        atan_tab[0]  = `RACER_CORDIC_ATAN_0;
        atan_tab[1]  = `RACER_CORDIC_ATAN_1;
        atan_tab[2]  = `RACER_CORDIC_ATAN_2;
        atan_tab[3]  = `RACER_CORDIC_ATAN_3;
        atan_tab[4]  = `RACER_CORDIC_ATAN_4;
        atan_tab[5]  = `RACER_CORDIC_ATAN_5;
        atan_tab[6]  = `RACER_CORDIC_ATAN_6;
        atan_tab[7]  = `RACER_CORDIC_ATAN_7;
        atan_tab[8]  = `RACER_CORDIC_ATAN_8;
        atan_tab[9]  = `RACER_CORDIC_ATAN_9;
        atan_tab[10] = `RACER_CORDIC_ATAN_10;
        atan_tab[11] = `RACER_CORDIC_ATAN_11;
        init_model();
    end

    function automatic int clamp_axis(input int sum, input int lo, input int hi);
        if (sum <= lo) return lo;
        if (sum >= hi) return hi;
        return sum;
    endfunction

    // nearest integer with halves rounded up
    function automatic int round_coord(input int p);
        return (p >>> `RACER_VFRAC) + ((p >>> (`RACER_VFRAC - 1)) & 1);
    endfunction

    task automatic rotate(input int c);
        int x;
        int y;
        int z;
        int xo;
        int a;
        int i;
        a = (head[c] >= 180) ? head[c] - 360 : head[c];
        x = speed[c];
        y = 0;
        if (a > 90) begin
            a = a - 180;
            x = -x;
        end else if (a < -90) begin
            a = a + 180;
            x = -x;
        end
        z = a * (1 << `RACER_CORDIC_AFRAC);
        for (i = 0; i < `RACER_CORDIC_ITER; i++) begin
            xo = x;
            if (z >= 0) begin
                x = x - (y >>> i);
                y = y + (xo >>> i);
                z = z - atan_tab[i];
            end else begin
                x = x + (y >>> i);
                y = y - (xo >>> i);
                z = z + atan_tab[i];
            end
        end
        vx[c] = (x * `RACER_CORDIC_GAIN) >>> 16;
        vy[c] = (y * `RACER_CORDIC_GAIN) >>> 16;
    endtask

    task automatic model_frame(input int c, input racer_pkg::car_cmd_t cmd);
        int v;
        px[c] = clamp_axis(px[c] + vx[c], XLO, XHI); // old vector
        py[c] = clamp_axis(py[c] + vy[c], YLO, YHI);
        if (!cmd.omega[0]) begin
            if (cmd.omega[1]) begin
                head[c] = (head[c] == 359) ? 0 : head[c] + 1;
            end else begin
                head[c] = (head[c] == 0) ? 359 : head[c] - 1;
            end
        end
        v = speed[c] - (speed[c] >>> `RACER_FRICTION_SHIFT);
        v = v + (int'(cmd.acc) << (`RACER_VFRAC - `RACER_AFRAC));
        if (v < 0) begin
            v = 0;
        end else if (v > VTOP) begin
            v = VTOP;
        end
        speed[c] = v;
        rotate(c);
    endtask

    task automatic note_failure(input string msg);
        test_errs++;
        total_errs++;
        $display("%s: %s", cur_test, msg);
    endtask

    task automatic check_field(input string car, input string field, input int exp, input int act);
        test_checks++;
        n_checks++;
        if (exp != act) begin
            test_errs++;
            total_errs++;
            $display("mismatch %s %s %s: expected %0d actual %0d",
                     cur_test, car, field, exp, act);
        end
    endtask

    task automatic compare_car(input int c, input racer_pkg::car_out_t o);
        string car;
        car = $sformatf("car%0d", c + 1);
        check_field(car, "heading", head[c], int'(o.heading));
        check_field(car, "x", round_coord(px[c]), int'(o.x));
        check_field(car, "y", round_coord(py[c]), int'(o.y));
        check_field(car, "speed", speed[c], int'(o.speed));
        if (int'(o.speed) < 0 || int'(o.speed) > VTOP) begin
            note_failure({car, " speed is outside the range from zero to the maximum"});
        end
        if (int'(o.x) < `RACER_XMIN || int'(o.x) > `RACER_XMAX ||
            int'(o.y) < `RACER_YMIN || int'(o.y) > `RACER_YMAX) begin
            note_failure({car, " left the arena"});
        end
    endtask

    task automatic check_now();
        compare_car(0, i_car1);
        compare_car(1, i_car2);
    endtask

    task automatic check_at_wall(input int c);
        racer_pkg::car_out_t o;
        o = (c == 0) ? i_car1 : i_car2;
        if (int'(o.x) != `RACER_XMIN && int'(o.x) != `RACER_XMAX &&
            int'(o.y) != `RACER_YMIN && int'(o.y) != `RACER_YMAX) begin
            note_failure($sformatf("car%0d never reached a wall", c + 1));
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic end_test();
        n_tests++;
        if (test_errs != 0) n_failed++;
        $display("test %s: %s, %0d checks, %0d errors", cur_test,
                 (test_errs == 0) ? "ok" : "FAILED", test_checks, test_errs);
    endtask

    task automatic report_totals();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, n_checks, total_errs);
    endtask

    // accepting edge advances the model
    always @(posedge car1_v_decomposition_done or negedge i_rst_n) begin
        if (!i_rst_n) begin
            init_model();
            pending     = 1'b0;
            busy_cycles = 0;
        end else begin
            if (pending) busy_cycles++;
            if (i_step && i_ready) begin
                if (pending) begin
                    note_failure("a frame was accepted before the previous one finished");
                end
                model_frame(0, i_car1_cmd);
                model_frame(1, i_car2_cmd);
                pending     = 1'b1;
                busy_cycles = 0;
            end
        end
    end

    // ready rises once both cars have collected their vectors
    always @(posedge i_ready) begin
        if (i_rst_n) begin
            if (pending) begin
                check_field("o_ready", "latency", READY_LAT, busy_cycles);
            end else begin
                note_failure("o_ready rose without an accepted frame");
            end
            check_now();
            pending = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_race_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_race_core;

    localparam int READY_LIMIT = 100; // cycles
    localparam logic [1:0] HOLD       = 2'b01;
    localparam logic [1:0] TURN_LEFT  = 2'b10;  // +1 degree
    localparam logic [1:0] TURN_RIGHT = 2'b00;  // -1 degree

    logic                car1_v_decomposition_done = 1'b0;
    logic                rst_n;
    logic                step;
    racer_pkg::car_cmd_t cmd1;
    racer_pkg::car_cmd_t cmd2;
    logic                ready;
    racer_pkg::car_out_t car1;
    racer_pkg::car_out_t car2;
    int                  err_count;
    integer              seed;

    always #10 car1_v_decomposition_done = ~car1_v_decomposition_done;

    race_core u_race_core (
        .car1_v_decomposition_done (car1_v_decomposition_done),
        .i_rst_n                   (rst_n),
        .i_step                    (step),
        .i_car1_cmd                (cmd1),
        .i_car2_cmd                (cmd2),
        .o_ready                   (ready),
        .o_car1                    (car1),
        .o_car2                    (car2)
    );

    race_checker u_checker (
        .car1_v_decomposition_done (car1_v_decomposition_done),
        .i_rst_n                   (rst_n),
        .i_step                    (step),
        .i_car1_cmd                (cmd1),
        .i_car2_cmd                (cmd2),
        .i_ready                   (ready),
        .i_car1                    (car1),
        .i_car2                    (car2),
        .o_errors                  (err_count)
    );

    function automatic racer_pkg::car_cmd_t make_cmd(input logic [2:0] acc,
                                                     input logic [1:0] omega);
        racer_pkg::car_cmd_t c;
        c.acc   = acc;
        c.omega = omega;
        return c;
    endfunction

    function automatic racer_pkg::car_cmd_t rand_cmd();
        logic [31:0] bits;
        bits = $random(seed);
        return bits[4:0];
    endfunction

    function automatic logic [1:0] rand_omega();
        racer_pkg::car_cmd_t c;
        c = rand_cmd();
        return c.omega;
    endfunction

    function automatic logic [2:0] rand_acc();
        racer_pkg::car_cmd_t c;
        c = rand_cmd();
        return c.acc;
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < READY_LIMIT) begin
            @(negedge car1_v_decomposition_done);
            n++;
        end
        if (!ready) u_checker.note_failure("o_ready never returned after a frame step");
    endtask

    // one accepted frame, optionally with extra steps during the busy window
    task automatic do_frame(input racer_pkg::car_cmd_t c1, input racer_pkg::car_cmd_t c2,
                            input int noise);
        wait_ready();
        step = 1'b1;
        cmd1 = c1;
        cmd2 = c2;
        @(negedge car1_v_decomposition_done);
        repeat (noise) begin
            cmd1 = rand_cmd();
            cmd2 = rand_cmd();
            @(negedge car1_v_decomposition_done);
        end
        step = 1'b0;
        wait_ready();
    endtask

    initial begin
        seed  = 32'hb3fd_4c82;
        rst_n = 1'b0;
        step  = 1'b0;
        cmd1  = '0;
        cmd2  = '0;
        repeat (16) @(negedge car1_v_decomposition_done);
        rst_n = 1'b1;
        @(negedge car1_v_decomposition_done);

        u_checker.begin_test("reset_state");
        if (!ready) u_checker.note_failure("o_ready is low after reset");
        u_checker.check_now();
        u_checker.end_test();

        // 90 down through 0 to 350, then back up across 359
        u_checker.begin_test("steer_wrap");
        repeat (5) do_frame(make_cmd(0, HOLD), make_cmd(0, HOLD), 0);
        repeat (100) do_frame(make_cmd(0, TURN_RIGHT), make_cmd(0, TURN_RIGHT), 0);
        repeat (30) do_frame(make_cmd(0, TURN_LEFT), make_cmd(0, TURN_LEFT), 0);
        repeat (20) do_frame(make_cmd(0, rand_omega()), make_cmd(0, rand_omega()), 0);
        u_checker.end_test();

        u_checker.begin_test("speed_friction_clamp");
        repeat (30) do_frame(make_cmd(rand_acc(), HOLD), make_cmd(rand_acc(), HOLD), 0);
        repeat (60) do_frame(make_cmd(7, HOLD), make_cmd(7, HOLD), 0);
        repeat (60) do_frame(make_cmd(0, HOLD), make_cmd(0, HOLD), 0); // coast down
        u_checker.end_test();

        u_checker.begin_test("position_track");
        repeat (200) do_frame(rand_cmd(), rand_cmd(), 0);
        u_checker.end_test();

        u_checker.begin_test("arena_clamp");
        repeat (300) do_frame(make_cmd(7, HOLD), make_cmd(7, HOLD), 0);
        u_checker.check_at_wall(0);
        u_checker.check_at_wall(1);
        u_checker.end_test();

        u_checker.begin_test("busy_drop");
        repeat (20) do_frame(rand_cmd(), rand_cmd(), 1 + ({$random(seed)} % 12));
        u_checker.end_test();

        u_checker.report_totals();
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/racer_pkg.sv
source/steer_angle.sv
source/speed_update.sv
source/cordic_rotate.sv
source/position_integrate.sv
source/car_dynamics.sv
source/race_core.sv
tb/race_checker.sv
tb/tb_race_core.sv
